// ==== hdl/popcnt_config.svh ====
`ifndef POPCNT_CONFIG_SVH
`define POPCNT_CONFIG_SVH

// ---------------------------------------------------------------------------
// sizes of the bit-counting service
// ---------------------------------------------------------------------------

// bits per request vector
`define POPCNT_WIDTH    16

// peer clients sharing the engine
`define POPCNT_CLIENTS  3

// credits per client, same as its queue depth
`define POPCNT_CREDITS  4

// derived sizes
`define POPCNT_CLIENT_W ((`POPCNT_CLIENTS > 1) ? $clog2(`POPCNT_CLIENTS) : 1)
`define POPCNT_CNT_W    ($clog2(`POPCNT_WIDTH) + 2)
`define POPCNT_LAT      ($clog2(`POPCNT_WIDTH) + 1)

`endif

// ==== hdl/popcnt_pkg.sv ====
`include "popcnt_config.svh"

package popcnt_pkg;

  // -------------------------------------------------------------------------
  // opcodes and arbiter states
  // -------------------------------------------------------------------------

  // what the engine counts
  typedef enum logic {
    OP_ONES  = 1'b0,
    OP_ZEROS = 1'b1
  } popcnt_op_e;

  // idle only while every client queue is empty
  typedef enum logic {
    ARB_IDLE  = 1'b0,
    ARB_GRANT = 1'b1
  } arb_state_e;

  // -------------------------------------------------------------------------
  // request, tag and result
  // -------------------------------------------------------------------------

  // one request from a client
  typedef struct packed {
    popcnt_op_e                op;
    logic [`POPCNT_WIDTH-1:0]  data;
  } popcnt_req_t;

  // travels beside the data through the counter
  typedef struct packed {
    logic [`POPCNT_CLIENT_W-1:0] client;
    popcnt_op_e                  op;
  } popcnt_tag_t;

  // one result on the shared bus
  typedef struct packed {
    logic [`POPCNT_CLIENT_W-1:0] client;
    logic [`POPCNT_CNT_W-1:0]    count;
  } popcnt_rsp_t;

endpackage

// ==== hdl/bit_population_counter.sv ====
`timescale 1ns/100ps

module bit_population_counter #(
  parameter int WIDTH = 16
)(
  input  logic                       clk_i,
  input  logic                       srst_i,
  input  logic [WIDTH-1:0]           data_i,
  input  logic                       data_val_i,

  output logic [$clog2(WIDTH)+1:0]   data_o,
  output logic                       data_val_o
);

  localparam int CNT_W  = $clog2(WIDTH) + 2;
  // padded up to a power of two so both halves are equal
  localparam int REAL_W = 1 << $clog2(WIDTH);

  logic [REAL_W-1:0] data_masked;

  // invalid input counts as all zeros
  always_comb
  begin
    data_masked = data_val_i ? REAL_W'(data_i) : '0;
  end

  generate
    if (WIDTH == 1)
    begin : g_leaf
      // -------------------------------------------------------------------
      // leaf: one bit, one register stage
      // -------------------------------------------------------------------
      always_ff @(posedge clk_i)
      begin
        if (srst_i)
          data_val_o <= 1'b0;
        else
          data_val_o <= data_val_i;
      end

      always_ff @(posedge clk_i)
      begin
        data_o <= CNT_W'(data_masked);
      end
    end
    else
    begin : g_node
      // -------------------------------------------------------------------
      // inner level: two half-width counters and an adder stage
      // -------------------------------------------------------------------
      localparam int HALF_W     = REAL_W / 2;
      localparam int HALF_CNT_W = $clog2(HALF_W) + 2;

      logic [HALF_CNT_W-1:0] lo_cnt;
      logic [HALF_CNT_W-1:0] hi_cnt;
      logic                  lo_val;
      logic                  hi_val;
      logic                  both_val;

      // lower half of the vector
      bit_population_counter #(
        .WIDTH      (HALF_W)
      ) u_lo (
        .clk_i      (clk_i),
        .srst_i     (srst_i),
        .data_i     (data_masked[HALF_W-1:0]),
        .data_val_i (data_val_i),
        .data_o     (lo_cnt),
        .data_val_o (lo_val)
      );

      // upper half of the vector
      bit_population_counter #(
        .WIDTH      (HALF_W)
      ) u_hi (
        .clk_i      (clk_i),
        .srst_i     (srst_i),
        .data_i     (data_masked[REAL_W-1:HALF_W]),
        .data_val_i (data_val_i),
        .data_o     (hi_cnt),
        .data_val_o (hi_val)
      );

      assign both_val = lo_val && hi_val;

      always_ff @(posedge clk_i)
      begin
        if (srst_i)
          data_val_o <= 1'b0;
        else
          data_val_o <= both_val;
      end

      // sum widens by one bit per level
      always_ff @(posedge clk_i)
      begin
        if (both_val)
          data_o <= CNT_W'(lo_cnt) + CNT_W'(hi_cnt);
        else
          data_o <= '0;
      end
    end
  endgenerate

endmodule

// ==== hdl/popcnt_arbiter.sv ====
`timescale 1ns/100ps
`include "popcnt_config.svh"

module popcnt_arbiter (
  input  logic                                            clk_i,
  input  logic                                            srst_i,

  input  logic [`POPCNT_CLIENTS-1:0]                      req_valid_i,
  input  popcnt_pkg::popcnt_req_t [`POPCNT_CLIENTS-1:0]   req_i,
  output logic [`POPCNT_CLIENTS-1:0]                      credit_o,

  output logic                                            grant_valid_o,
  output popcnt_pkg::popcnt_req_t                         grant_req_o,
  output popcnt_pkg::popcnt_tag_t                         grant_tag_o
);

  localparam int N     = `POPCNT_CLIENTS;
  localparam int DEPTH = `POPCNT_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int IDX_W = `POPCNT_CLIENT_W;

  popcnt_pkg::popcnt_req_t [N-1:0] head_req;
  logic [N-1:0]                    q_empty;
  logic [N-1:0]                    nonempty_d;
  logic [N-1:0]                    pop;

  logic [IDX_W-1:0]                rr_ptr;
  logic [IDX_W-1:0]                pick;
  logic                            pick_found;
  logic                            grant_en;

  popcnt_pkg::arb_state_e          state_q;

  // ---------------------------------------------------------------------------
  // per-client request queues
  // ---------------------------------------------------------------------------
  generate
    for (genvar c = 0; c < N; c++)
    begin : g_queue
      popcnt_pkg::popcnt_req_t mem [DEPTH];
      logic [PTR_W-1:0]        wr_ptr;
      logic [PTR_W-1:0]        rd_ptr;
      logic [CNT_W-1:0]        cnt;
      logic [CNT_W-1:0]        cnt_d;

      assign q_empty[c]  = (cnt == '0);
      assign head_req[c] = mem[rd_ptr];
      assign pop[c]      = grant_en && (pick == IDX_W'(c));

      always_comb
      begin
        cnt_d = cnt + CNT_W'(req_valid_i[c]) - CNT_W'(pop[c]);
      end

      assign nonempty_d[c] = (cnt_d != '0);

      always_ff @(posedge clk_i)
      begin
        if (srst_i)
        begin
          wr_ptr <= '0;
          rd_ptr <= '0;
          cnt    <= '0;
        end
        else
        begin
          cnt <= cnt_d;
          if (req_valid_i[c])
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
          if (pop[c])
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
      end

      always_ff @(posedge clk_i)
      begin
        if (req_valid_i[c])
          mem[wr_ptr] <= req_i[c];
      end

      // a client without credit would push into a full queue
      a_no_overflow: assert property (
        @(posedge clk_i) disable iff (srst_i)
        req_valid_i[c] |-> (cnt != CNT_W'(DEPTH))
      );
    end
  endgenerate

  // ---------------------------------------------------------------------------
  // round-robin pick
  // ---------------------------------------------------------------------------

  // first non-empty queue at or after rr_ptr
  always_comb
  begin
    int idx;
    pick       = '0;
    pick_found = 1'b0;
    for (int off = 0; off < N; off++)
    begin
      idx = int'(rr_ptr) + off;
      if (idx >= N)
        idx = idx - N;
      if (!pick_found && !q_empty[idx])
      begin
        pick       = IDX_W'(idx);
        pick_found = 1'b1;
      end
    end
  end

  assign grant_en = pick_found && (state_q == popcnt_pkg::ARB_GRANT);

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      state_q       <= popcnt_pkg::ARB_IDLE;
      rr_ptr        <= '0;
      grant_valid_o <= 1'b0;
      credit_o      <= '0;
    end
    else
    begin
      state_q       <= (|nonempty_d) ? popcnt_pkg::ARB_GRANT : popcnt_pkg::ARB_IDLE;
      grant_valid_o <= grant_en;
      // credit goes back in the same cycle as the grant
      credit_o      <= pop;
      if (grant_en)
        rr_ptr <= (pick == IDX_W'(N - 1)) ? '0 : pick + 1'b1;
    end
  end

  // grant payload
  always_ff @(posedge clk_i)
  begin
    grant_req_o        <= head_req[pick];
    grant_tag_o.client <= pick;
    grant_tag_o.op     <= head_req[pick].op;
  end

  a_one_credit: assert property (
    @(posedge clk_i) disable iff (srst_i)
    $onehot0(credit_o)
  );

endmodule

// ==== hdl/popcnt_engine.sv ====
`timescale 1ns/100ps
`include "popcnt_config.svh"

module popcnt_engine (
  input  logic                      clk_i,
  input  logic                      srst_i,

  input  logic                      grant_valid_i,
  input  popcnt_pkg::popcnt_req_t   grant_req_i,
  input  popcnt_pkg::popcnt_tag_t   grant_tag_i,

  output logic                      rsp_valid_o,
  output popcnt_pkg::popcnt_rsp_t   rsp_o
);

  localparam int LAT   = `POPCNT_LAT;
  localparam int CNT_W = `POPCNT_CNT_W;

  logic [CNT_W-1:0]          ones_cnt;
  logic                      ones_val;

  logic [LAT-1:0]            tag_val;
  popcnt_pkg::popcnt_tag_t   tag_pipe [LAT];
  popcnt_pkg::popcnt_tag_t   tag_out;

  // ---------------------------------------------------------------------------
  // ones counter
  // ---------------------------------------------------------------------------
  bit_population_counter #(
    .WIDTH      (`POPCNT_WIDTH)
  ) u_counter (
    .clk_i      (clk_i),
    .srst_i     (srst_i),
    .data_i     (grant_req_i.data),
    .data_val_i (grant_valid_i),
    .data_o     (ones_cnt),
    .data_val_o (ones_val)
  );

  // ---------------------------------------------------------------------------
  // tag pipeline, same depth as the counter
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      tag_val <= '0;
    else
    begin
      tag_val[0] <= grant_valid_i;
      for (int i = 1; i < LAT; i++)
        tag_val[i] <= tag_val[i-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    tag_pipe[0] <= grant_tag_i;
    for (int i = 1; i < LAT; i++)
      tag_pipe[i] <= tag_pipe[i-1];
  end

  assign tag_out = tag_pipe[LAT-1];

  // ---------------------------------------------------------------------------
  // result bus
  // ---------------------------------------------------------------------------
  assign rsp_valid_o = tag_val[LAT-1];

  // zeros are whatever the ones leave over
  always_comb
  begin
    rsp_o.client = tag_out.client;
    if (tag_out.op == popcnt_pkg::OP_ZEROS)
      rsp_o.count = CNT_W'(`POPCNT_WIDTH) - ones_cnt;
    else
      rsp_o.count = ones_cnt;
  end

  // tag must line up with the counter output
  a_tag_align: assert property (
    @(posedge clk_i) disable iff (srst_i)
    tag_val[LAT-1] == ones_val
  );

endmodule

// ==== hdl/popcnt_top.sv ====
`timescale 1ns/100ps
`include "popcnt_config.svh"

module popcnt_top (
  input  logic                                            clk_i,
  input  logic                                            srst_i,

  // client side
  input  logic [`POPCNT_CLIENTS-1:0]                      req_valid_i,
  input  popcnt_pkg::popcnt_req_t [`POPCNT_CLIENTS-1:0]   req_i,
  output logic [`POPCNT_CLIENTS-1:0]                      credit_o,

  // shared result bus
  output logic                                            rsp_valid_o,
  output popcnt_pkg::popcnt_rsp_t                         rsp_o
);

  logic                      grant_valid;
  popcnt_pkg::popcnt_req_t   grant_req;
  popcnt_pkg::popcnt_tag_t   grant_tag;

  // ---------------------------------------------------------------------------
  // queues and round-robin grant
  // ---------------------------------------------------------------------------
  popcnt_arbiter u_arbiter (
    .clk_i         (clk_i),
    .srst_i        (srst_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .credit_o      (credit_o),
    .grant_valid_o (grant_valid),
    .grant_req_o   (grant_req),
    .grant_tag_o   (grant_tag)
  );

  // ---------------------------------------------------------------------------
  // counting pipeline
  // ---------------------------------------------------------------------------
  popcnt_engine u_engine (
    .clk_i         (clk_i),
    .srst_i        (srst_i),
    .grant_valid_i (grant_valid),
    .grant_req_i   (grant_req),
    .grant_tag_i   (grant_tag),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 3
)(
  output logic clk_o,
  output logic srst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset held for the first few rising edges
  initial
  begin
    srst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    srst_o <= 1'b0;
  end

endmodule

// ==== bench/popcnt_tb.sv ====
`timescale 1ns/100ps
`include "popcnt_config.svh"

module popcnt_tb;

  localparam int N           = `POPCNT_CLIENTS;
  localparam int W           = `POPCNT_WIDTH;
  localparam int CREDITS     = `POPCNT_CREDITS;
  localparam int CNT_W       = $clog2(W) + 2;
  localparam int L           = $clog2(W) + 1;
  localparam int RAND_CYCLES = 200;

  // worst-case length of each test in cycles
  localparam int T_RESET  = 10;
  localparam int T_SINGLE = N * 6 * (L + 4);
  localparam int T_CREDIT = CREDITS + L + 10;
  localparam int T_FAIR   = N * CREDITS + L + 10;
  localparam int T_RAND   = RAND_CYCLES + N * CREDITS + L + 10;
  localparam int TIMEOUT  = 2 * (T_RESET + T_SINGLE + T_CREDIT + T_FAIR + T_RAND);

  logic                            clk_i;
  logic                            srst_i;
  logic [N-1:0]                    req_valid_i;
  popcnt_pkg::popcnt_req_t [N-1:0] req_i;
  logic [N-1:0]                    credit_o;
  logic                            rsp_valid_o;
  popcnt_pkg::popcnt_rsp_t         rsp_o;

  int               credits [N];
  logic [CNT_W-1:0] exp_q [N][$];
  int               issue_q [N][$];
  int               cycle = 0;
  int               value_errors = 0;
  int               protocol_errors = 0;
  int               seed;
  logic             quiet_check = 1'b1;
  logic             latency_check = 1'b0;
  logic             rotation_check = 1'b0;
  int               last_client = -1;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .srst_o (srst_i)
  );

  popcnt_top u_dut (
    .clk_i       (clk_i),
    .srst_i      (srst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .credit_o    (credit_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  // ---------------------------------------------------------------------------
  // reference count and request helpers
  // ---------------------------------------------------------------------------
  function automatic logic [CNT_W-1:0] expected_count(popcnt_pkg::popcnt_req_t r);
    int ones;
    ones = 0;
    for (int i = 0; i < W; i++)
      if (r.data[i])
        ones++;
    if (r.op == popcnt_pkg::OP_ZEROS)
      return CNT_W'(W - ones);
    return CNT_W'(ones);
  endfunction

  function automatic popcnt_pkg::popcnt_req_t make_req(logic zeros, logic [W-1:0] data);
    popcnt_pkg::popcnt_req_t r;
    r.op   = zeros ? popcnt_pkg::OP_ZEROS : popcnt_pkg::OP_ONES;
    r.data = data;
    return r;
  endfunction

  // one cycle of client inputs and the credits it spends
  task automatic drive_cycle(input logic [N-1:0] valid,
                             input popcnt_pkg::popcnt_req_t [N-1:0] reqs);
    @(posedge clk_i);
    for (int c = 0; c < N; c++)
    begin
      if (valid[c])
      begin
        assert (credits[c] > 0)
        else
        begin
          protocol_errors++;
          $display("client %0d sent a request without a credit at %0t", c, $time);
        end
        credits[c]--;
      end
    end
    req_valid_i <= valid;
    req_i       <= reqs;
  endtask

  // all results back and all credits home
  task automatic wait_drain();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(posedge clk_i);
      busy = 1'b0;
      for (int c = 0; c < N; c++)
        if (exp_q[c].size() != 0 || credits[c] != CREDITS)
          busy = 1'b1;
    end
  endtask

  // ---------------------------------------------------------------------------
  // cycle counter and timeout
  // ---------------------------------------------------------------------------
  always @(posedge clk_i)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // monitor and scoreboard sampled mid-cycle
  // ---------------------------------------------------------------------------
  always @(negedge clk_i)
  begin
    int               c;
    int               issued;
    logic [CNT_W-1:0] exp_cnt;
    logic             outstanding;
    if (quiet_check)
    begin
      assert (rsp_valid_o == 1'b0 && credit_o == '0)
      else
      begin
        protocol_errors++;
        $display("result bus or credits active before the first request at %0t", $time);
      end
    end
    if (!srst_i)
    begin
      for (int i = 0; i < N; i++)
      begin
        // sampled by the DUT at the next edge
        if (req_valid_i[i])
        begin
          exp_q[i].push_back(expected_count(req_i[i]));
          issue_q[i].push_back(cycle + 1);
        end
        if (credit_o[i])
        begin
          credits[i]++;
          assert (credits[i] <= CREDITS)
          else
          begin
            protocol_errors++;
            $display("client %0d got back more credits than it holds at %0t", i, $time);
          end
        end
      end
      if (rsp_valid_o)
      begin
        c           = int'(rsp_o.client);
        outstanding = (c < N) ? (exp_q[c].size() != 0) : 1'b0;
        assert (outstanding)
        else
        begin
          protocol_errors++;
          $display("result for client %0d with nothing outstanding at %0t", c, $time);
        end
        if (outstanding)
        begin
          exp_cnt = exp_q[c].pop_front();
          issued  = issue_q[c].pop_front();
          assert (rsp_o.count == exp_cnt)
          else
          begin
            value_errors++;
            $display("[ERROR] %0t rsp_o.count (client %0d) expected %0d actual %0d",
                     $time, c, exp_cnt, rsp_o.count);
          end
          if (latency_check)
          begin
            assert (cycle - issued == L + 1)
            else
            begin
              value_errors++;
              $display("[ERROR] %0t rsp_valid_o latency (client %0d) expected %0d actual %0d",
                       $time, c, L + 1, cycle - issued);
            end
          end
          if (rotation_check && last_client >= 0)
          begin
            assert (c == (last_client + 1) % N)
            else
            begin
              value_errors++;
              $display("[ERROR] %0t rsp_o.client expected %0d actual %0d",
                       $time, (last_client + 1) % N, c);
            end
          end
          last_client = c;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------------
  task automatic reset_quiet();
    while (srst_i)
      @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    quiet_check = 1'b0;
  endtask

  // no contention so the latency is fixed
  task automatic single_requests();
    logic [W-1:0]                    vec [3];
    popcnt_pkg::popcnt_req_t [N-1:0] reqs;
    latency_check = 1'b1;
    for (int c = 0; c < N; c++)
    begin
      vec[0] = '0;
      vec[1] = '1;
      vec[2] = W'(1) << ((c * 5 + 3) % W);
      for (int v = 0; v < 3; v++)
      begin
        for (int o = 0; o < 2; o++)
        begin
          reqs    = '0;
          reqs[c] = make_req(o[0], vec[v]);
          drive_cycle(N'(1) << c, reqs);
          drive_cycle('0, '0);
          wait_drain();
        end
      end
    end
    latency_check = 1'b0;
  endtask

  task automatic credit_exhaustion();
    popcnt_pkg::popcnt_req_t [N-1:0] reqs;
    int                              cl;
    cl   = N - 1;
    reqs = '0;
    for (int i = 0; i < CREDITS; i++)
    begin
      reqs[cl] = make_req(i[0], W'($random(seed)));
      drive_cycle(N'(1) << cl, reqs);
    end
    drive_cycle('0, '0);
    wait_drain();
  endtask

  // every client pushes in the same cycles
  task automatic round_robin_rotation();
    popcnt_pkg::popcnt_req_t [N-1:0] reqs;
    last_client    = -1;
    rotation_check = 1'b1;
    for (int i = 0; i < CREDITS; i++)
    begin
      for (int c = 0; c < N; c++)
        reqs[c] = make_req($random(seed) & 1, W'($random(seed)));
      drive_cycle('1, reqs);
    end
    drive_cycle('0, '0);
    wait_drain();
    rotation_check = 1'b0;
  endtask

  task automatic random_traffic();
    popcnt_pkg::popcnt_req_t [N-1:0] reqs;
    logic [N-1:0]                    valid;
    for (int i = 0; i < RAND_CYCLES; i++)
    begin
      valid = '0;
      reqs  = '0;
      for (int c = 0; c < N; c++)
      begin
        if (credits[c] > 0 && ($random(seed) & 1))
        begin
          valid[c] = 1'b1;
          reqs[c]  = make_req($random(seed) & 1, W'($random(seed)));
        end
      end
      drive_cycle(valid, reqs);
    end
    drive_cycle('0, '0);
    wait_drain();
  endtask

  initial
  begin
    req_valid_i = '0;
    req_i       = '0;
    seed        = 32'h540a_41e8;
    for (int c = 0; c < N; c++)
      credits[c] = CREDITS;
    reset_quiet();
    single_requests();
    credit_exhaustion();
    round_robin_rotation();
    random_traffic();
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/popcnt_pkg.sv
hdl/bit_population_counter.sv
hdl/popcnt_arbiter.sv
hdl/popcnt_engine.sv
hdl/popcnt_top.sv
bench/tb_clk_gen.sv
bench/popcnt_tb.sv
